/* src/lsu_pkg.sv */
package lsu_pkg;

    // datapath and byte-enable widths
    localparam int XLEN   = 32;
    localparam int MASK_W = 4;

    // memory operation sent by the pipeline
    typedef enum logic [3:0] {
        NONE,
        LB,
        LBU,
        LH,
        LHU,
        LW,
        SB,
        SH,
        SW,
        LR_W,
        SC_W,
        AMO
    } mem_op_e;

    // read-modify-write flavour, only meaningful with AMO
    typedef enum logic [3:0] {
        SWAP,
        ADD,
        XOR,
        AND,
        OR,
        MIN,
        MAX,
        MINU,
        MAXU
    } amo_op_e;

    // clint timer words, served on the side bus
    localparam logic [XLEN-1:0] MTIME_LO    = 32'h0200_BFF8;
    localparam logic [XLEN-1:0] MTIME_HI    = 32'h0200_BFFC;
    localparam logic [XLEN-1:0] MTIMECMP_LO = 32'h0200_4000;
    localparam logic [XLEN-1:0] MTIMECMP_HI = 32'h0200_4004;

    // one operation from the pipeline, wdata is rs2
    typedef struct packed {
        logic            valid;
        mem_op_e         mem_op;
        amo_op_e         amo_op;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
    } lsu_op_t;

    // answer to the pipeline, done is a single-cycle pulse
    typedef struct packed {
        logic            done;
        logic [XLEN-1:0] data;
        logic            misalign;
    } lsu_result_t;

    // data cache request
    typedef struct packed {
        logic              valid;
        logic              write;
        logic [XLEN-1:0]   addr;
        logic [MASK_W-1:0] mask;
        logic [XLEN-1:0]   wdata;
    } dbus_req_t;

    // data cache response, rdata valid with ready
    typedef struct packed {
        logic            ready;
        logic [XLEN-1:0] rdata;
    } dbus_resp_t;

    // clint side bus, always completes in one cycle
    typedef struct packed {
        logic            valid;
        logic            write;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
    } clint_req_t;

endpackage

/* src/byte_lane_unit.sv */
`timescale 1ns/100ps

module byte_lane_unit (
    input  lsu_pkg::mem_op_e           mem_op_i,
    input  logic [1:0]                 addr_lo_i,
    input  logic [lsu_pkg::XLEN-1:0]   store_data_i,
    input  logic [lsu_pkg::XLEN-1:0]   load_raw_i,
    output logic [lsu_pkg::MASK_W-1:0] mask_o,
    output logic [lsu_pkg::XLEN-1:0]   store_data_o,
    output logic [lsu_pkg::XLEN-1:0]   load_data_o
);
    import lsu_pkg::*;

    logic [MASK_W-1:0] size_mask;
    logic [XLEN-1:0]   lane_word;

    // access size as an unshifted byte mask
    always_comb begin
        case (mem_op_i)
            LB, LBU, SB: size_mask = 4'b0001;
            LH, LHU, SH: size_mask = 4'b0011;
            LW, SW:      size_mask = 4'b1111;
            default:     size_mask = 4'b0000;
        endcase
    end

    // mask moved to the addressed lanes, for reads as well as writes
    assign mask_o = size_mask << addr_lo_i;

    // store data moves up by the byte offset
    assign store_data_o = store_data_i << {addr_lo_i, 3'b000};

    // addressed lane brought down to bit 0
    assign lane_word = load_raw_i >> {addr_lo_i, 3'b000};

    // sign or zero extension by operation
    always_comb begin
        case (mem_op_i)
            LB:      load_data_o = {{24{lane_word[7]}}, lane_word[7:0]};
            LBU:     load_data_o = {24'b0, lane_word[7:0]};
            LH:      load_data_o = {{16{lane_word[15]}}, lane_word[15:0]};
            LHU:     load_data_o = {16'b0, lane_word[15:0]};
            // full word, nothing to extend
            default: load_data_o = lane_word;
        endcase
    end

endmodule

/* src/load_store_path.sv */
`timescale 1ns/100ps

module load_store_path (
    input  lsu_pkg::lsu_op_t     op_i,
    input  lsu_pkg::dbus_resp_t  resp_i,
    output lsu_pkg::dbus_req_t   req_o,
    output lsu_pkg::lsu_result_t result_o,
    output logic                 store_seen_o
);
    import lsu_pkg::*;

    logic              is_load;
    logic              is_store;
    logic              plain;
    logic [MASK_W-1:0] lane_mask;
    logic [XLEN-1:0]   lane_wdata;
    logic [XLEN-1:0]   load_ext;

    // plain accesses only, atomics belong to the sequencer
    assign is_load  = op_i.mem_op inside {LB, LBU, LH, LHU, LW};
    assign is_store = op_i.mem_op inside {SB, SH, SW};
    assign plain    = op_i.valid & (is_load | is_store);

    byte_lane_unit u_lanes (
        .mem_op_i     (op_i.mem_op),
        .addr_lo_i    (op_i.addr[1:0]),
        .store_data_i (op_i.wdata),
        .load_raw_i   (resp_i.rdata),
        .mask_o       (lane_mask),
        .store_data_o (lane_wdata),
        .load_data_o  (load_ext)
    );

    // request held for as long as the op is presented
    assign req_o.valid = plain;
    assign req_o.write = is_store;
    assign req_o.addr  = {op_i.addr[XLEN-1:2], 2'b00};
    assign req_o.mask  = lane_mask;
    assign req_o.wdata = lane_wdata;

    // completes in the ready cycle, stores return zero
    assign result_o.done     = plain & resp_i.ready;
    assign result_o.data     = (result_o.done & is_load) ? load_ext : '0;
    assign result_o.misalign = 1'b0;

    // a finished plain store kills any reservation
    assign store_seen_o = result_o.done & is_store;

endmodule

/* src/amo_alu.sv */
`timescale 1ns/100ps

module amo_alu (
    input  lsu_pkg::amo_op_e         amo_op_i,
    input  logic [lsu_pkg::XLEN-1:0] mem_val_i,
    input  logic [lsu_pkg::XLEN-1:0] rs2_i,
    output logic [lsu_pkg::XLEN-1:0] new_val_o
);
    import lsu_pkg::*;

    logic lt_signed;
    logic lt_unsigned;

    // memory value against rs2, both orderings
    assign lt_signed   = $signed(mem_val_i) < $signed(rs2_i);
    assign lt_unsigned = mem_val_i < rs2_i;

    always_comb begin
        case (amo_op_i)
            ADD:     new_val_o = mem_val_i + rs2_i;
            XOR:     new_val_o = mem_val_i ^ rs2_i;
            AND:     new_val_o = mem_val_i & rs2_i;
            OR:      new_val_o = mem_val_i | rs2_i;
            MIN:     new_val_o = lt_signed ? mem_val_i : rs2_i;
            MAX:     new_val_o = lt_signed ? rs2_i : mem_val_i;
            MINU:    new_val_o = lt_unsigned ? mem_val_i : rs2_i;
            MAXU:    new_val_o = lt_unsigned ? rs2_i : mem_val_i;
            // swap, and anything undefined behaves as swap
            default: new_val_o = rs2_i;
        endcase
    end

endmodule

/* src/amo_sequencer.sv */
`timescale 1ns/100ps

module amo_sequencer (
    input  logic                 clk,
    input  logic                 rst,
    input  lsu_pkg::lsu_op_t     op_i,
    input  lsu_pkg::dbus_resp_t  resp_i,
    input  logic                 store_seen_i,
    output lsu_pkg::dbus_req_t   req_o,
    output lsu_pkg::lsu_result_t result_o
);
    import lsu_pkg::*;

    typedef enum logic [2:0] {IDLE, LOAD, CALC, STORE, DONE} state_e;

    state_e          state_q;
    logic            is_lr;
    logic            is_sc;
    logic            is_atomic;
    logic            misaligned;
    logic            sc_match;
    logic            res_valid_q;
    logic [XLEN-1:0] res_addr_q;
    logic [XLEN-1:0] load_q;
    logic [XLEN-1:0] calc_q;
    logic [XLEN-1:0] alu_val;
    logic            misalign_q;
    logic            sc_fail_q;

    assign is_lr      = op_i.mem_op == LR_W;
    assign is_sc      = op_i.mem_op == SC_W;
    assign is_atomic  = op_i.valid & (is_lr | is_sc | (op_i.mem_op == AMO));
    assign misaligned = op_i.addr[1:0] != 2'b00;

    // sc only succeeds on the exact reserved word
    assign sc_match = res_valid_q & (res_addr_q == op_i.addr);

    amo_alu u_alu (
        .amo_op_i  (op_i.amo_op),
        .mem_val_i (load_q),
        .rs2_i     (op_i.wdata),
        .new_val_o (alu_val)
    );

    // control state
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q     <= IDLE;
            res_valid_q <= 1'b0;
            misalign_q  <= 1'b0;
            sc_fail_q   <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (is_atomic) begin
                        misalign_q <= misaligned;
                        sc_fail_q  <= is_sc & ~sc_match;
                        // any sc consumes the reservation
                        if (is_sc) begin
                            res_valid_q <= 1'b0;
                        end
                        if (misaligned) begin
                            // flagged, no bus traffic
                            state_q <= DONE;
                        end else if (is_sc) begin
                            state_q <= sc_match ? STORE : DONE;
                        end else begin
                            state_q <= LOAD;
                        end
                    end
                end
                LOAD: begin
                    if (resp_i.ready) begin
                        if (is_lr) begin
                            res_valid_q <= 1'b1;
                            state_q     <= DONE;
                        end else begin
                            state_q <= CALC;
                        end
                    end
                end
                // one cycle for the alu result
                CALC: state_q <= STORE;
                STORE: begin
                    if (resp_i.ready) begin
                        state_q <= DONE;
                    end
                end
                DONE: state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
            // plain store from the other path wins over everything
            if (store_seen_i) begin
                res_valid_q <= 1'b0;
            end
        end
    end

    // loaded word, alu result and reserved address
    always_ff @(posedge clk) begin
        if (state_q == LOAD && resp_i.ready) begin
            load_q <= resp_i.rdata;
            if (is_lr) begin
                res_addr_q <= op_i.addr;
            end
        end
        if (state_q == CALC) begin
            calc_q <= alu_val;
        end
    end

    // word access, sc writes rs2 and amo the alu result
    assign req_o.valid = (state_q == LOAD) | (state_q == STORE);
    assign req_o.write = state_q == STORE;
    assign req_o.addr  = {op_i.addr[XLEN-1:2], 2'b00};
    assign req_o.mask  = '1;
    assign req_o.wdata = is_sc ? op_i.wdata : calc_q;

    // done straight from the state register
    assign result_o.done     = state_q == DONE;
    assign result_o.misalign = result_o.done & misalign_q;

    // old word for lr and amo, 0 or 1 for sc
    always_comb begin
        if (state_q != DONE || misalign_q) begin
            result_o.data = '0;
        end else if (is_sc) begin
            result_o.data = {{(XLEN-1){1'b0}}, sc_fail_q};
        end else begin
            result_o.data = load_q;
        end
    end

endmodule

/* src/data_bus_arbiter.sv */
`timescale 1ns/100ps

module data_bus_arbiter (
    input  lsu_pkg::dbus_req_t       plain_req_i,
    input  lsu_pkg::dbus_req_t       amo_req_i,
    input  lsu_pkg::dbus_resp_t      dbus_resp_i,
    input  logic [lsu_pkg::XLEN-1:0] clint_rdata_i,
    output lsu_pkg::dbus_resp_t      plain_resp_o,
    output lsu_pkg::dbus_resp_t      amo_resp_o,
    output lsu_pkg::dbus_req_t       dbus_req_o,
    output lsu_pkg::clint_req_t      clint_req_o
);
    import lsu_pkg::*;

    logic       grant_amo;
    logic       clint_hit;
    dbus_req_t  sel_req;
    dbus_resp_t sel_resp;

    // sequencer has priority whenever it asks
    assign grant_amo = amo_req_i.valid;
    assign sel_req   = grant_amo ? amo_req_i : plain_req_i;

    // exact match on the four timer words
    assign clint_hit = sel_req.valid &
                       (sel_req.addr inside {MTIME_LO, MTIME_HI, MTIMECMP_LO, MTIMECMP_HI});

    // only one bus sees valid
    always_comb begin
        dbus_req_o       = sel_req;
        dbus_req_o.valid = sel_req.valid & ~clint_hit;
    end

    assign clint_req_o.valid = clint_hit;
    assign clint_req_o.write = sel_req.write;
    assign clint_req_o.addr  = sel_req.addr;
    assign clint_req_o.wdata = sel_req.wdata;

    // clint answers at once, cache when it is ready
    assign sel_resp.ready = clint_hit | dbus_resp_i.ready;
    assign sel_resp.rdata = clint_hit ? clint_rdata_i : dbus_resp_i.rdata;

    // loser sees an idle response
    assign amo_resp_o   = grant_amo ? sel_resp : '0;
    assign plain_resp_o = grant_amo ? '0 : sel_resp;

endmodule

/* src/lsu_top.sv */
`timescale 1ns/100ps

module lsu_top (
    input  logic                     clk,
    input  logic                     rst,
    input  lsu_pkg::lsu_op_t         op_i,
    output lsu_pkg::lsu_result_t     result_o,
    output logic                     stall_o,
    output lsu_pkg::dbus_req_t       dbus_req_o,
    input  lsu_pkg::dbus_resp_t      dbus_resp_i,
    output lsu_pkg::clint_req_t      clint_req_o,
    input  logic [lsu_pkg::XLEN-1:0] clint_rdata_i
);
    import lsu_pkg::*;

    dbus_req_t   plain_req;
    dbus_req_t   amo_req;
    dbus_resp_t  plain_resp;
    dbus_resp_t  amo_resp;
    lsu_result_t plain_res;
    lsu_result_t amo_res;
    logic        store_seen;

    load_store_path u_plain (
        .op_i         (op_i),
        .resp_i       (plain_resp),
        .req_o        (plain_req),
        .result_o     (plain_res),
        .store_seen_o (store_seen)
    );

    amo_sequencer u_amo (
        .clk          (clk),
        .rst          (rst),
        .op_i         (op_i),
        .resp_i       (amo_resp),
        .store_seen_i (store_seen),
        .req_o        (amo_req),
        .result_o     (amo_res)
    );

    data_bus_arbiter u_arb (
        .plain_req_i   (plain_req),
        .amo_req_i     (amo_req),
        .dbus_resp_i   (dbus_resp_i),
        .clint_rdata_i (clint_rdata_i),
        .plain_resp_o  (plain_resp),
        .amo_resp_o    (amo_resp),
        .dbus_req_o    (dbus_req_o),
        .clint_req_o   (clint_req_o)
    );

    // at most one side finishes in a cycle
    assign result_o.done     = plain_res.done | amo_res.done;
    assign result_o.data     = amo_res.done ? amo_res.data : plain_res.data;
    assign result_o.misalign = plain_res.misalign | amo_res.misalign;

    // pipeline waits until this op is done
    assign stall_o = op_i.valid & ~result_o.done;

endmodule

/* bench/lsu_mem_model.sv */
`timescale 1ns/100ps

module lsu_mem_model (
    input  logic                     clk,
    input  logic                     rst,
    input  lsu_pkg::dbus_req_t       dbus_req_i,
    output lsu_pkg::dbus_resp_t      dbus_resp_o,
    input  lsu_pkg::clint_req_t      clint_req_i,
    output logic [lsu_pkg::XLEN-1:0] clint_rdata_o,
    output int                       stray_cnt_o
);
    import lsu_pkg::*;

    logic [XLEN-1:0] mem [16];
    logic [63:0]     mtime_q;
    logic [XLEN-1:0] mtimecmp_lo_q;
    logic [XLEN-1:0] mtimecmp_hi_q;
    logic            ready_q;
    logic [XLEN-1:0] rdata_q;
    logic [1:0]      wait_q;
    logic [3:0]      idx;
    integer          seed;
    int              k;

    initial seed = 32682;

    // 16 words, folded onto addr[5:2]
    assign idx = dbus_req_i.addr[5:2];
    assign dbus_resp_o.ready = ready_q;
    assign dbus_resp_o.rdata = rdata_q;

    // every nibble pair carries the word index
    function automatic logic [XLEN-1:0] fill_word(input logic [3:0] i);
        return {i, 4'hC, i, 4'h3, i, 4'hA, i, 4'h5};
    endfunction

    // cache side, ready after 1 to 3 cycles
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            ready_q     <= 1'b0;
            rdata_q     <= '0;
            wait_q      <= 2'd1;
            stray_cnt_o <= 0;
            for (k = 0; k < 16; k++) begin
                mem[k] <= fill_word(k[3:0]);
            end
        end else if (ready_q) begin
            // transfer done, pick the next latency
            ready_q <= 1'b0;
            wait_q  <= 2'({$random(seed)} % 3);
        end else if (dbus_req_i.valid) begin
            if (wait_q != 2'd0) begin
                wait_q <= wait_q - 2'd1;
            end else begin
                ready_q <= 1'b1;
                rdata_q <= mem[idx];
                if (dbus_req_i.write) begin
                    for (k = 0; k < MASK_W; k++) begin
                        if (dbus_req_i.mask[k]) begin
                            mem[idx][8*k +: 8] <= dbus_req_i.wdata[8*k +: 8];
                        end
                    end
                end
                // timer space must never reach the cache
                if (dbus_req_i.addr[31:16] == 16'h0200) begin
                    $display("ERROR: data cache got a request for CLINT address %h",
                             dbus_req_i.addr);
                    stray_cnt_o <= stray_cnt_o + 1;
                end
            end
        end
    end

    // clint registers, read combinationally
    always_comb begin
        case (clint_req_i.addr)
            MTIME_LO:    clint_rdata_o = mtime_q[31:0];
            MTIME_HI:    clint_rdata_o = mtime_q[63:32];
            MTIMECMP_LO: clint_rdata_o = mtimecmp_lo_q;
            MTIMECMP_HI: clint_rdata_o = mtimecmp_hi_q;
            default:     clint_rdata_o = '0;
        endcase
    end

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            mtime_q       <= '0;
            mtimecmp_lo_q <= '1;
            mtimecmp_hi_q <= '1;
        end else begin
            mtime_q <= mtime_q + 64'd1;
            // mtime itself is read only here
            if (clint_req_i.valid && clint_req_i.write) begin
                if (clint_req_i.addr == MTIMECMP_LO) begin
                    mtimecmp_lo_q <= clint_req_i.wdata;
                end
                if (clint_req_i.addr == MTIMECMP_HI) begin
                    mtimecmp_hi_q <= clint_req_i.wdata;
                end
            end
        end
    end

endmodule

/* bench/lsu_tb.sv */
`timescale 1ns/100ps

module lsu_tb;
    import lsu_pkg::*;

    // one row of the stimulus table
    typedef struct packed {
        mem_op_e         op;
        amo_op_e         amo;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
        logic [XLEN-1:0] exp_data;
        logic            exp_mis;
    } step_t;

    logic            clk;
    logic            rst;
    lsu_op_t         op;
    lsu_result_t     result;
    logic            stall;
    dbus_req_t       dbus_req;
    dbus_resp_t      dbus_resp;
    clint_req_t      clint_req;
    logic [XLEN-1:0] clint_rdata;
    int              stray_cnt;
    int              err_cnt;
    int              cycle_cnt;
    bit              table_built = 1'b0;
    step_t           steps[$];

    lsu_top UUT (
        .clk           (clk),
        .rst           (rst),
        .op_i          (op),
        .result_o      (result),
        .stall_o       (stall),
        .dbus_req_o    (dbus_req),
        .dbus_resp_i   (dbus_resp),
        .clint_req_o   (clint_req),
        .clint_rdata_i (clint_rdata)
    );

    lsu_mem_model u_mem (
        .clk           (clk),
        .rst           (rst),
        .dbus_req_i    (dbus_req),
        .dbus_resp_o   (dbus_resp),
        .clint_req_i   (clint_req),
        .clint_rdata_o (clint_rdata),
        .stray_cnt_o   (stray_cnt)
    );

    // 40 ns clock
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic add_step(input mem_op_e mop, input amo_op_e aop,
                            input logic [XLEN-1:0] addr, input logic [XLEN-1:0] wdata,
                            input logic [XLEN-1:0] exp_data, input logic exp_mis);
        step_t s;
        s.op       = mop;
        s.amo      = aop;
        s.addr     = addr;
        s.wdata    = wdata;
        s.exp_data = exp_data;
        s.exp_mis  = exp_mis;
        steps.push_back(s);
    endtask

    task automatic check_equal(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("FAILED at %0d ns: %s, got %h expected %h", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    // called on a falling edge, returns on a falling edge
    task automatic run_step(input step_t s, input int idx);
        int cycles;
        op.valid  = 1'b1;
        op.mem_op = s.op;
        op.amo_op = s.amo;
        op.addr   = s.addr;
        op.wdata  = s.wdata;
        // presentation cycle counts as the first
        cycles = 1;
        do begin
            @(negedge clk);
            cycles++;
            // pipeline must be held while the op is pending
            if (result.done !== 1'b1) begin
                check_equal(32'(stall), 32'd1, $sformatf("step %0d stall while pending", idx));
            end
        end while (result.done !== 1'b1);
        check_equal(result.data, s.exp_data, $sformatf("step %0d data", idx));
        check_equal(32'(result.misalign), 32'(s.exp_mis), $sformatf("step %0d misalign", idx));
        check_equal(32'(stall), 32'd0, $sformatf("step %0d stall with done", idx));
        if (s.exp_mis) begin
            check_equal(cycles, 32'd2, $sformatf("step %0d misaligned latency", idx));
        end
        // op stays up for the rest of the done cycle
        @(negedge clk);
    endtask

    initial begin
        op      = '0;
        rst     = 1'b1;
        err_cnt = 0;

        // word 8 has every byte negative
        add_step(LB,   SWAP, 32'h20, 32'h0, 32'hFFFF_FF85, 1'b0);
        add_step(LB,   SWAP, 32'h21, 32'h0, 32'hFFFF_FF8A, 1'b0);
        add_step(LB,   SWAP, 32'h22, 32'h0, 32'hFFFF_FF83, 1'b0);
        add_step(LB,   SWAP, 32'h23, 32'h0, 32'hFFFF_FF8C, 1'b0);
        add_step(LBU,  SWAP, 32'h20, 32'h0, 32'h0000_0085, 1'b0);
        add_step(LBU,  SWAP, 32'h21, 32'h0, 32'h0000_008A, 1'b0);
        add_step(LBU,  SWAP, 32'h22, 32'h0, 32'h0000_0083, 1'b0);
        add_step(LBU,  SWAP, 32'h23, 32'h0, 32'h0000_008C, 1'b0);
        // positive byte of word 1
        add_step(LB,   SWAP, 32'h05, 32'h0, 32'h0000_001A, 1'b0);
        add_step(LH,   SWAP, 32'h20, 32'h0, 32'hFFFF_8A85, 1'b0);
        add_step(LH,   SWAP, 32'h22, 32'h0, 32'hFFFF_8C83, 1'b0);
        add_step(LHU,  SWAP, 32'h20, 32'h0, 32'h0000_8A85, 1'b0);
        add_step(LHU,  SWAP, 32'h22, 32'h0, 32'h0000_8C83, 1'b0);
        add_step(LW,   SWAP, 32'h20, 32'h0, 32'h8C83_8A85, 1'b0);

        // partial stores into words 2 and 3
        add_step(SB,   SWAP, 32'h08, 32'h0000_00E1, 32'h0, 1'b0);
        add_step(SB,   SWAP, 32'h0B, 32'hFFFF_FFE4, 32'h0, 1'b0);
        add_step(LW,   SWAP, 32'h08, 32'h0, 32'hE423_2AE1, 1'b0);
        add_step(SB,   SWAP, 32'h0D, 32'h0000_0077, 32'h0, 1'b0);
        add_step(SB,   SWAP, 32'h0E, 32'h0000_0066, 32'h0, 1'b0);
        add_step(LW,   SWAP, 32'h0C, 32'h0, 32'h3C66_7735, 1'b0);
        add_step(SH,   SWAP, 32'h0A, 32'h0000_BEEF, 32'h0, 1'b0);
        add_step(LW,   SWAP, 32'h08, 32'h0, 32'hBEEF_2AE1, 1'b0);
        add_step(SH,   SWAP, 32'h0C, 32'hABCD_1234, 32'h0, 1'b0);
        add_step(LW,   SWAP, 32'h0C, 32'h0, 32'h3C66_1234, 1'b0);

        // amo returns the old word, lw shows the new one
        add_step(AMO,  SWAP, 32'h10, 32'h1234_5678, 32'h4C43_4A45, 1'b0);
        add_step(LW,   SWAP, 32'h10, 32'h0, 32'h1234_5678, 1'b0);
        add_step(AMO,  ADD,  32'h14, 32'h1111_1111, 32'h5C53_5A55, 1'b0);
        add_step(LW,   SWAP, 32'h14, 32'h0, 32'h6D64_6B66, 1'b0);
        add_step(AMO,  XOR,  32'h18, 32'hFFFF_0000, 32'h6C63_6A65, 1'b0);
        add_step(LW,   SWAP, 32'h18, 32'h0, 32'h939C_6A65, 1'b0);
        add_step(AMO,  AND,  32'h1C, 32'h0F0F_F0F0, 32'h7C73_7A75, 1'b0);
        add_step(LW,   SWAP, 32'h1C, 32'h0, 32'h0C03_7070, 1'b0);
        add_step(AMO,  OR,   32'h24, 32'h0000_0F0F, 32'h9C93_9A95, 1'b0);
        add_step(LW,   SWAP, 32'h24, 32'h0, 32'h9C93_9F9F, 1'b0);
        // negative memory words against a small positive rs2
        add_step(AMO,  MIN,  32'h28, 32'h0000_0005, 32'hACA3_AAA5, 1'b0);
        add_step(LW,   SWAP, 32'h28, 32'h0, 32'hACA3_AAA5, 1'b0);
        add_step(AMO,  MAX,  32'h2C, 32'h0000_0005, 32'hBCB3_BAB5, 1'b0);
        add_step(LW,   SWAP, 32'h2C, 32'h0, 32'h0000_0005, 1'b0);
        add_step(AMO,  MINU, 32'h30, 32'h0000_0005, 32'hCCC3_CAC5, 1'b0);
        add_step(LW,   SWAP, 32'h30, 32'h0, 32'h0000_0005, 1'b0);
        add_step(AMO,  MAXU, 32'h34, 32'h0000_0005, 32'hDCD3_DAD5, 1'b0);
        add_step(LW,   SWAP, 32'h34, 32'h0, 32'hDCD3_DAD5, 1'b0);
        // both operands negative
        add_step(AMO,  MAX,  32'h38, 32'hF000_0000, 32'hECE3_EAE5, 1'b0);
        add_step(LW,   SWAP, 32'h38, 32'h0, 32'hF000_0000, 1'b0);
        add_step(AMO,  MINU, 32'h3C, 32'h8000_0000, 32'hFCF3_FAF5, 1'b0);
        add_step(LW,   SWAP, 32'h3C, 32'h0, 32'h8000_0000, 1'b0);

        // reservation on word 1
        add_step(LR_W, SWAP, 32'h04, 32'h0, 32'h1C13_1A15, 1'b0);
        add_step(SC_W, SWAP, 32'h04, 32'h5C5C_0001, 32'h0, 1'b0);
        add_step(LW,   SWAP, 32'h04, 32'h0, 32'h5C5C_0001, 1'b0);
        add_step(SC_W, SWAP, 32'h04, 32'hDEAD_0002, 32'h1, 1'b0);
        add_step(LW,   SWAP, 32'h04, 32'h0, 32'h5C5C_0001, 1'b0);
        add_step(LR_W, SWAP, 32'h04, 32'h0, 32'h5C5C_0001, 1'b0);
        add_step(SW,   SWAP, 32'h04, 32'h0BAD_0003, 32'h0, 1'b0);
        add_step(SC_W, SWAP, 32'h04, 32'hDEAD_0004, 32'h1, 1'b0);
        add_step(LW,   SWAP, 32'h04, 32'h0, 32'h0BAD_0003, 1'b0);

        // timer compare registers on the side bus
        add_step(SW,   SWAP, MTIMECMP_LO, 32'h1357_9BDF, 32'h0, 1'b0);
        add_step(SW,   SWAP, MTIMECMP_HI, 32'h0000_0042, 32'h0, 1'b0);
        add_step(LW,   SWAP, MTIMECMP_LO, 32'h0, 32'h1357_9BDF, 1'b0);
        add_step(LW,   SWAP, MTIMECMP_HI, 32'h0, 32'h0000_0042, 1'b0);

        // misaligned atomics, memory must stay as it was
        add_step(AMO,  ADD,  32'h0E, 32'h0000_0001, 32'h0, 1'b1);
        add_step(LR_W, SWAP, 32'h21, 32'h0, 32'h0, 1'b1);
        add_step(SC_W, SWAP, 32'h06, 32'hFFFF_FFFF, 32'h0, 1'b1);
        add_step(LW,   SWAP, 32'h0C, 32'h0, 32'h3C66_1234, 1'b0);
        add_step(LW,   SWAP, 32'h20, 32'h0, 32'h8C83_8A85, 1'b0);
        add_step(LW,   SWAP, 32'h04, 32'h0, 32'h0BAD_0003, 1'b0);
        table_built = 1'b1;

        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        foreach (steps[i]) begin
            run_step(steps[i], i);
        end
        op = '0;

        $display("summary: %0d value errors, %0d cache requests to CLINT addresses",
                 err_cnt, stray_cnt);
        if (err_cnt == 0 && stray_cnt == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // budget of 20 cycles per step plus reset
    initial begin : watchdog
        int limit;
        wait (table_built);
        limit     = steps.size() * 20 + 50;
        cycle_cnt = 0;
        while (cycle_cnt < limit) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("ERROR: timeout after %0d cycles, an operation never finished", cycle_cnt);
        $display(">>> FAIL");
        $finish;
    end

endmodule

/* project.f */
src/lsu_pkg.sv
src/byte_lane_unit.sv
src/load_store_path.sv
src/amo_alu.sv
src/amo_sequencer.sv
src/data_bus_arbiter.sv
src/lsu_top.sv
bench/lsu_mem_model.sv
bench/lsu_tb.sv
